/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module icobrd_tb -f build.f -o icobrd_sim
	./obj_dir/icobrd_sim | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* build.f */
verilog/icobrd_pkg.sv
verilog/icobrd_ifs.sv
verilog/fw_loader.sv
verilog/boot_mem.sv
verilog/pmod_gpio.sv
verilog/io_bus_decoder.sv
verilog/icobrd_soc.sv
tests/icobrd_tb.sv

/* tests/icobrd_tb.sv */
// directed testbench for the board memory and I/O block; top module icobrd_tb, run from build.f
`timescale 1ns/1ps

module icobrd_tb;

	localparam int WAIT_LIMIT = 50;
	localparam int FW_WORDS = 8;
	localparam icobrd_pkg::word_t LED_ADDR = 32'h2000_0000;
	localparam icobrd_pkg::word_t CON_ADDR = 32'h3000_0000;

	logic clk;
	logic resetn;
	logic bus_valid;
	icobrd_pkg::word_t bus_addr;
	icobrd_pkg::word_t bus_wdata;
	icobrd_pkg::strb_t bus_wstrb;
	logic bus_ready;
	icobrd_pkg::word_t bus_rdata;
	logic ld_sync;
	logic ld_valid;
	icobrd_pkg::byte_t ld_data;
	logic con_tx_valid;
	icobrd_pkg::byte_t con_tx_data;
	logic con_tx_ready;
	logic con_rx_valid;
	icobrd_pkg::byte_t con_rx_data;
	logic con_rx_ready;
	icobrd_pkg::led_t leds;
	logic cpu_resetn;
	icobrd_pkg::gpio_t [icobrd_pkg::NUM_PMODS-1:0] pmod_dir;
	icobrd_pkg::gpio_t [icobrd_pkg::NUM_PMODS-1:0] pmod_out;
	icobrd_pkg::gpio_t [icobrd_pkg::NUM_PMODS-1:0] pmod_in;

	int errors;
	int timeouts;
	// con_rx_ready as seen in the bus ready cycle
	logic rx_pop;
	icobrd_pkg::byte_t fw_bytes [$];

	icobrd_soc UUT (
		.clk          (clk),
		.resetn       (resetn),
		.bus_valid    (bus_valid),
		.bus_addr     (bus_addr),
		.bus_wdata    (bus_wdata),
		.bus_wstrb    (bus_wstrb),
		.bus_ready    (bus_ready),
		.bus_rdata    (bus_rdata),
		.ld_sync      (ld_sync),
		.ld_valid     (ld_valid),
		.ld_data      (ld_data),
		.con_tx_valid (con_tx_valid),
		.con_tx_data  (con_tx_data),
		.con_tx_ready (con_tx_ready),
		.con_rx_valid (con_rx_valid),
		.con_rx_data  (con_rx_data),
		.con_rx_ready (con_rx_ready),
		.leds         (leds),
		.cpu_resetn   (cpu_resetn),
		.pmod_dir     (pmod_dir),
		.pmod_out     (pmod_out),
		.pmod_in      (pmod_in)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// --------------------------------------------------
	// compare tasks

	task automatic check_word(input string name, input icobrd_pkg::word_t got,
			input icobrd_pkg::word_t exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic check_byte(input string name, input icobrd_pkg::byte_t got,
			input icobrd_pkg::byte_t exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic check_gpio(input string name, input icobrd_pkg::gpio_t got,
			input icobrd_pkg::gpio_t exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic check_led(input string name, input icobrd_pkg::led_t got,
			input icobrd_pkg::led_t exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	// --------------------------------------------------
	// bus and loader drivers

	task automatic bus_access(input icobrd_pkg::word_t addr, input icobrd_pkg::word_t wdata,
			input icobrd_pkg::strb_t strb, output icobrd_pkg::word_t rdata);
		int cycles;
		cycles = 0;
		@(posedge clk);
		#2;
		bus_valid = 1'b1;
		bus_addr = addr;
		bus_wdata = wdata;
		bus_wstrb = strb;
		@(negedge clk);
		while (!bus_ready && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!bus_ready) begin
			$display("timeout: no bus ready for address 0x%h", addr);
			timeouts++;
		end
		rdata = bus_rdata;
		rx_pop = con_rx_ready;
		@(posedge clk);
		#2;
		bus_valid = 1'b0;
		bus_wstrb = '0;
		// ready lasts a single cycle
		check_bit("bus_ready", bus_ready, 1'b0);
	endtask

	task automatic bus_write(input icobrd_pkg::word_t addr, input icobrd_pkg::word_t wdata,
			input icobrd_pkg::strb_t strb);
		icobrd_pkg::word_t unused;
		bus_access(addr, wdata, strb, unused);
	endtask

	task automatic bus_read(input icobrd_pkg::word_t addr, output icobrd_pkg::word_t rdata);
		bus_access(addr, '0, 4'h0, rdata);
	endtask

	task automatic pulse_sync();
		@(posedge clk);
		#2;
		ld_sync = 1'b1;
		@(posedge clk);
		#2;
		ld_sync = 1'b0;
	endtask

	task automatic send_byte(input icobrd_pkg::byte_t data);
		@(posedge clk);
		#2;
		ld_valid = 1'b1;
		ld_data = data;
		@(posedge clk);
		#2;
		ld_valid = 1'b0;
	endtask

	// console sink, takes one byte when it shows up
	task automatic accept_tx_byte(input icobrd_pkg::byte_t exp);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!con_tx_valid && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!con_tx_valid) begin
			$display("timeout: console byte never became valid");
			timeouts++;
		end
		check_byte("con_tx_data", con_tx_data, exp);
		@(posedge clk);
		#2;
		con_tx_ready = 1'b1;
		@(posedge clk);
		#2;
		con_tx_ready = 1'b0;
	endtask

	function automatic icobrd_pkg::word_t merge_lanes(input icobrd_pkg::word_t old_word,
			input icobrd_pkg::word_t new_word, input icobrd_pkg::strb_t strb);
		icobrd_pkg::word_t result;
		result = old_word;
		for (int lane = 0; lane < 4; lane++) begin
			if (strb[lane])
				result[8*lane +: 8] = new_word[8*lane +: 8];
		end
		return result;
	endfunction

	// --------------------------------------------------
	// tests

	task automatic firmware_load();
		icobrd_pkg::byte_t data;
		icobrd_pkg::word_t got;
		icobrd_pkg::word_t exp;
		fw_bytes.delete();
		pulse_sync();
		for (int i = 0; i < 4 * FW_WORDS; i++) begin
			data = icobrd_pkg::byte_t'($urandom);
			fw_bytes.push_back(data);
			send_byte(data);
		end
		@(negedge clk);
		check_bit("cpu_resetn", cpu_resetn, 1'b0);
		pulse_sync();
		@(negedge clk);
		check_bit("cpu_resetn", cpu_resetn, 1'b1);
		for (int w = 0; w < FW_WORDS; w++) begin
			bus_read(icobrd_pkg::word_t'(4 * w), got);
			exp = {fw_bytes[4*w+3], fw_bytes[4*w+2], fw_bytes[4*w+1], fw_bytes[4*w]};
			check_word("bus_rdata", got, exp);
		end
	endtask

	task automatic ram_byte_strobes();
		icobrd_pkg::strb_t patterns [4] = '{4'b0001, 4'b0110, 4'b1010, 4'b1000};
		icobrd_pkg::word_t addr;
		icobrd_pkg::word_t full;
		icobrd_pkg::word_t part;
		icobrd_pkg::word_t got;
		for (int k = 0; k < 4; k++) begin
			addr = 32'h0000_0400 + icobrd_pkg::word_t'(4 * k);
			full = $urandom;
			part = $urandom;
			bus_write(addr, full, 4'hf);
			bus_write(addr, part, patterns[k]);
			bus_read(addr, got);
			check_word("bus_rdata", got, merge_lanes(full, part, patterns[k]));
		end
	endtask

	task automatic led_register();
		icobrd_pkg::word_t value;
		icobrd_pkg::word_t got;
		for (int k = 0; k < 2; k++) begin
			value = $urandom;
			bus_write(LED_ADDR, value, 4'hf);
			check_led("leds", leds, value[2:0]);
			bus_read(LED_ADDR, got);
			check_word("bus_rdata", got, icobrd_pkg::word_t'(value[2:0]));
		end
	endtask

	task automatic pmod_ports();
		icobrd_pkg::word_t base;
		icobrd_pkg::word_t got;
		icobrd_pkg::gpio_t dir_val;
		icobrd_pkg::gpio_t out_val;
		icobrd_pkg::gpio_t in_val;
		for (int i = 0; i < icobrd_pkg::NUM_PMODS; i++) begin
			// port i lives on io page i + 1
			base = 32'h2000_0000 | (icobrd_pkg::word_t'(i + 1) << 8);
			dir_val = icobrd_pkg::gpio_t'($urandom);
			out_val = icobrd_pkg::gpio_t'($urandom);
			in_val = icobrd_pkg::gpio_t'($urandom);
			bus_write(base | icobrd_pkg::word_t'(icobrd_pkg::PMOD_REG_DIR),
				icobrd_pkg::word_t'(dir_val), 4'h1);
			bus_write(base | icobrd_pkg::word_t'(icobrd_pkg::PMOD_REG_OUT),
				icobrd_pkg::word_t'(out_val), 4'h1);
			check_gpio($sformatf("pmod_dir[%0d]", i), pmod_dir[i], dir_val);
			check_gpio($sformatf("pmod_out[%0d]", i), pmod_out[i], out_val);
			bus_read(base | icobrd_pkg::word_t'(icobrd_pkg::PMOD_REG_DIR), got);
			check_word("bus_rdata", got, icobrd_pkg::word_t'(dir_val));
			bus_read(base | icobrd_pkg::word_t'(icobrd_pkg::PMOD_REG_OUT), got);
			check_word("bus_rdata", got, icobrd_pkg::word_t'(out_val));
			pmod_in[i] = in_val;
			bus_read(base | icobrd_pkg::word_t'(icobrd_pkg::PMOD_REG_IN), got);
			check_word("bus_rdata", got, icobrd_pkg::word_t'(in_val));
		end
	endtask

	task automatic console_tx_backpressure();
		icobrd_pkg::byte_t first;
		icobrd_pkg::byte_t second;
		logic second_done;
		first = icobrd_pkg::byte_t'($urandom);
		second = icobrd_pkg::byte_t'($urandom);
		second_done = 1'b0;
		bus_write(CON_ADDR, icobrd_pkg::word_t'(first), 4'h1);
		check_bit("con_tx_valid", con_tx_valid, 1'b1);
		fork
			begin
				bus_write(CON_ADDR, icobrd_pkg::word_t'(second), 4'h1);
				second_done = 1'b1;
			end
			begin
				repeat (8) @(negedge clk);
				if (second_done) begin
					$display("second console write finished while the first byte was pending");
					errors++;
				end
				check_byte("con_tx_data", con_tx_data, first);
				accept_tx_byte(first);
				accept_tx_byte(second);
			end
		join
		@(negedge clk);
		check_bit("con_tx_valid", con_tx_valid, 1'b0);
	endtask

	task automatic console_rx();
		icobrd_pkg::byte_t data;
		icobrd_pkg::word_t got;
		data = icobrd_pkg::byte_t'($urandom);
		@(posedge clk);
		#2;
		con_rx_valid = 1'b1;
		con_rx_data = data;
		bus_read(CON_ADDR, got);
		check_word("bus_rdata", got, icobrd_pkg::word_t'(data));
		check_bit("con_rx_ready", rx_pop, 1'b1);
		con_rx_valid = 1'b0;
		// nothing waiting reads as all ones
		bus_read(CON_ADDR, got);
		check_word("bus_rdata", got, 32'hffff_ffff);
		check_bit("con_rx_ready", rx_pop, 1'b0);
	endtask

	task automatic reset_hold();
		bus_write(LED_ADDR, 32'h0000_0005, 4'hf);
		bus_write(CON_ADDR, 32'h0000_00a5, 4'h1);
		check_led("leds", leds, 3'h5);
		check_bit("con_tx_valid", con_tx_valid, 1'b1);
		send_byte(icobrd_pkg::byte_t'($urandom));
		repeat (3) @(negedge clk);
		check_bit("cpu_resetn", cpu_resetn, 1'b0);
		check_led("leds", leds, 3'h0);
		check_bit("con_tx_valid", con_tx_valid, 1'b0);
	endtask

	// --------------------------------------------------
	// main sequence

	initial begin
		errors = 0;
		timeouts = 0;
		rx_pop = 1'b0;
		void'($urandom(59066));
		resetn = 1'b0;
		bus_valid = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		bus_wstrb = '0;
		ld_sync = 1'b0;
		ld_valid = 1'b0;
		ld_data = '0;
		con_tx_ready = 1'b0;
		con_rx_valid = 1'b0;
		con_rx_data = '0;
		pmod_in = '0;
		repeat (5) @(posedge clk);
		#2;
		resetn = 1'b1;

		firmware_load();
		ram_byte_strobes();
		led_register();
		pmod_ports();
		console_tx_backpressure();
		console_rx();
		reset_hold();

		$display("errors: %0d value mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* verilog/boot_mem.sv */
// boot RAM: word memory with byte-strobed bus writes and a loader write port
`timescale 1ns/1ps

module boot_mem (
	input logic                   clk,
	boot_mem_if.ram               bus,
	input logic                   ld_we,
	input icobrd_pkg::mem_index_t ld_index,
	input icobrd_pkg::word_t      ld_word
);

	icobrd_pkg::word_t mem [icobrd_pkg::BOOT_MEM_WORDS];

	// --------------------------------------------------
	// single port, loader first

	always_ff @(posedge clk) begin
		if (ld_we) begin
			mem[ld_index] <= ld_word;
		end else if (bus.en) begin
			if (|bus.wstrb) begin
				// per byte lane
				for (int lane = 0; lane < $bits(icobrd_pkg::strb_t); lane++) begin
					if (bus.wstrb[lane])
						mem[bus.index][8*lane +: 8] <= bus.wdata[8*lane +: 8];
				end
			end else begin
				bus.rdata <= mem[bus.index];
			end
		end
	end

endmodule

/* verilog/fw_loader.sv */
// firmware loader: packs the loader byte stream into boot RAM words and holds the CPU in reset
`timescale 1ns/1ps

module fw_loader (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   ld_sync,
	input  logic                   ld_valid,
	input  icobrd_pkg::byte_t      ld_data,
	output logic                   ld_we,
	output icobrd_pkg::mem_index_t ld_index,
	output icobrd_pkg::word_t      ld_word,
	output logic                   cpu_resetn
);

	logic [1:0]        byte_cnt;
	logic              hold;
	icobrd_pkg::word_t shift_word;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			byte_cnt <= '0;
			ld_index <= '0;
			hold <= 1'b0;
			ld_we <= 1'b0;
		end else begin
			ld_we <= 1'b0;
			if (ld_sync) begin
				byte_cnt <= '0;
				ld_index <= '0;
				hold <= 1'b0;
			end else begin
				// index moves on once the word is in
				if (ld_we)
					ld_index <= ld_index + 1'b1;
				if (ld_valid) begin
					byte_cnt <= byte_cnt + 1'b1;
					hold <= 1'b1;
					if (byte_cnt == 2'd3)
						ld_we <= 1'b1;
				end
			end
		end
	end

	// new byte enters at the top, first byte ends up lowest
	always_ff @(posedge clk) begin
		if (ld_valid)
			shift_word <= {ld_data, shift_word[31:8]};
	end

	assign ld_word = shift_word;
	assign cpu_resetn = resetn && !hold;

endmodule

/* verilog/icobrd_ifs.sv */
// boot RAM port and PMOD control port interfaces used between the decoder and its targets
`timescale 1ns/1ps

// --------------------------------------------------
// boot ram port, bus side

interface boot_mem_if;
	logic                   en;
	icobrd_pkg::strb_t      wstrb;
	icobrd_pkg::mem_index_t index;
	icobrd_pkg::word_t      wdata;
	// registered read word
	icobrd_pkg::word_t      rdata;

	modport ctrl (
		output en,
		output wstrb,
		output index,
		output wdata,
		input  rdata
	);

	modport ram (
		input  en,
		input  wstrb,
		input  index,
		input  wdata,
		output rdata
	);
endinterface

// --------------------------------------------------
// one pmod port's register access

interface pmod_ctrl_if;
	logic                  wr;
	logic                  rd;
	icobrd_pkg::pmod_reg_t addr;
	icobrd_pkg::gpio_t     wdat;
	icobrd_pkg::gpio_t     rdat;
	logic                  done;

	modport host (output wr, output rd, output addr, output wdat, input rdat, input done);

	modport dev (input wr, input rd, input addr, input wdat, output rdat, output done);
endinterface

/* verilog/icobrd_pkg.sv */
// address map, widths and shared types for the board memory and I/O block; compile first
package icobrd_pkg;

	// --------------------------------------------------
	// widths with a meaning

	typedef logic [31:0] word_t;
	typedef logic [7:0]  byte_t;
	typedef logic [3:0]  strb_t;
	typedef logic [7:0]  gpio_t;
	typedef logic [2:0]  led_t;
	typedef logic [9:0]  mem_index_t;
	typedef logic [7:0]  pmod_reg_t;

	// bus decoder states
	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_PMOD,
		BUS_RESP
	} bus_state_t;

	// --------------------------------------------------
	// address map

	localparam int BOOT_MEM_WORDS = 1024;

	// top address nibble
	localparam logic [3:0] IO_REGION      = 4'h2;
	localparam logic [3:0] CONSOLE_REGION = 4'h3;

	// io page is address bits 15:8, pmod ports follow the led page
	localparam int        NUM_PMODS = 4;
	localparam logic [7:0] LED_PAGE = 8'h00;

	localparam pmod_reg_t PMOD_REG_DIR = 8'h00;
	localparam pmod_reg_t PMOD_REG_OUT = 8'h04;
	localparam pmod_reg_t PMOD_REG_IN  = 8'h08;

	localparam word_t CONSOLE_EMPTY = '1;

endpackage

/* verilog/icobrd_soc.sv */
// top level of the board memory and I/O block: loader, boot RAM, bus decoder and PMOD ports
`timescale 1ns/1ps

module icobrd_soc (
	input  logic              clk,
	input  logic              resetn,

	// cpu bus
	input  logic              bus_valid,
	input  icobrd_pkg::word_t bus_addr,
	input  icobrd_pkg::word_t bus_wdata,
	input  icobrd_pkg::strb_t bus_wstrb,
	output logic              bus_ready,
	output icobrd_pkg::word_t bus_rdata,

	// firmware loader stream
	input  logic              ld_sync,
	input  logic              ld_valid,
	input  icobrd_pkg::byte_t ld_data,

	// console
	output logic              con_tx_valid,
	output icobrd_pkg::byte_t con_tx_data,
	input  logic              con_tx_ready,
	input  logic              con_rx_valid,
	input  icobrd_pkg::byte_t con_rx_data,
	output logic              con_rx_ready,

	output icobrd_pkg::led_t  leds,
	output logic              cpu_resetn,
	output icobrd_pkg::gpio_t [icobrd_pkg::NUM_PMODS-1:0] pmod_dir,
	output icobrd_pkg::gpio_t [icobrd_pkg::NUM_PMODS-1:0] pmod_out,
	input  icobrd_pkg::gpio_t [icobrd_pkg::NUM_PMODS-1:0] pmod_in
);

	logic                   ld_we;
	icobrd_pkg::mem_index_t ld_index;
	icobrd_pkg::word_t      ld_word;

	boot_mem_if  ram_bus ();
	pmod_ctrl_if pmod_bus [icobrd_pkg::NUM_PMODS] ();

	fw_loader loader (
		.clk        (clk),
		.resetn     (resetn),
		.ld_sync    (ld_sync),
		.ld_valid   (ld_valid),
		.ld_data    (ld_data),
		.ld_we      (ld_we),
		.ld_index   (ld_index),
		.ld_word    (ld_word),
		.cpu_resetn (cpu_resetn)
	);

	boot_mem ram (
		.clk      (clk),
		.bus      (ram_bus.ram),
		.ld_we    (ld_we),
		.ld_index (ld_index),
		.ld_word  (ld_word)
	);

	io_bus_decoder decoder (
		.clk          (clk),
		.cpu_resetn   (cpu_resetn),
		.bus_valid    (bus_valid),
		.bus_addr     (bus_addr),
		.bus_wdata    (bus_wdata),
		.bus_wstrb    (bus_wstrb),
		.bus_ready    (bus_ready),
		.bus_rdata    (bus_rdata),
		.leds         (leds),
		.con_tx_valid (con_tx_valid),
		.con_tx_data  (con_tx_data),
		.con_tx_ready (con_tx_ready),
		.con_rx_valid (con_rx_valid),
		.con_rx_data  (con_rx_data),
		.con_rx_ready (con_rx_ready),
		.ram          (ram_bus.ctrl),
		.pmod         (pmod_bus)
	);

	// pmod registers share the cpu reset
	for (genvar i = 0; i < icobrd_pkg::NUM_PMODS; i++) begin : g_pmod
		pmod_gpio port (
			.clk     (clk),
			.resetn  (cpu_resetn),
			.ctrl    (pmod_bus[i]),
			.pad_in  (pmod_in[i]),
			.pad_dir (pmod_dir[i]),
			.pad_out (pmod_out[i])
		);
	end

endmodule

/* verilog/io_bus_decoder.sv */
// CPU bus decoder: routes accesses to boot RAM, LED register, PMOD ports and the console
`timescale 1ns/1ps

module io_bus_decoder (
	input  logic              clk,
	input  logic              cpu_resetn,
	input  logic              bus_valid,
	input  icobrd_pkg::word_t bus_addr,
	input  icobrd_pkg::word_t bus_wdata,
	input  icobrd_pkg::strb_t bus_wstrb,
	output logic              bus_ready,
	output icobrd_pkg::word_t bus_rdata,
	output icobrd_pkg::led_t  leds,
	output logic              con_tx_valid,
	output icobrd_pkg::byte_t con_tx_data,
	input  logic              con_tx_ready,
	input  logic              con_rx_valid,
	input  icobrd_pkg::byte_t con_rx_data,
	output logic              con_rx_ready,
	boot_mem_if.ctrl          ram,
	pmod_ctrl_if.host         pmod [icobrd_pkg::NUM_PMODS]
);

	icobrd_pkg::bus_state_t state;

	logic [7:0] io_page;
	logic       is_write;
	logic       ram_hit;
	logic       io_hit;
	logic       con_hit;
	logic       led_hit;
	logic       tx_free;

	logic [icobrd_pkg::NUM_PMODS-1:0] pmod_hit;
	logic [icobrd_pkg::NUM_PMODS-1:0] pmod_sel;
	logic [icobrd_pkg::NUM_PMODS-1:0] pmod_wr;
	logic [icobrd_pkg::NUM_PMODS-1:0] pmod_rd;
	logic [icobrd_pkg::NUM_PMODS-1:0] pmod_done;

	icobrd_pkg::gpio_t     pmod_rdat_vec [icobrd_pkg::NUM_PMODS];
	icobrd_pkg::gpio_t     pmod_rdat;
	icobrd_pkg::pmod_reg_t pmod_addr;
	icobrd_pkg::gpio_t     pmod_wdat;
	icobrd_pkg::word_t     rdata_q;
	logic                  ram_resp;

	// --------------------------------------------------
	// address decode

	always_comb begin
		io_page = bus_addr[15:8];
		is_write = |bus_wstrb;
		ram_hit = bus_addr[31:2] < 30'(icobrd_pkg::BOOT_MEM_WORDS);
		io_hit = bus_addr[31:28] == icobrd_pkg::IO_REGION;
		con_hit = bus_addr[31:28] == icobrd_pkg::CONSOLE_REGION;
		led_hit = io_hit && (io_page == icobrd_pkg::LED_PAGE);
		tx_free = !con_tx_valid || con_tx_ready;
		// pmod ports sit on the pages after the led page
		for (int i = 0; i < icobrd_pkg::NUM_PMODS; i++)
			pmod_hit[i] = io_page == 8'(i + 1);
		pmod_rdat = '0;
		for (int i = 0; i < icobrd_pkg::NUM_PMODS; i++) begin
			if (pmod_sel[i])
				pmod_rdat = pmod_rdat | pmod_rdat_vec[i];
		end
	end

	// ram is addressed in the sampling cycle, its register feeds the response
	assign ram.en = (state == icobrd_pkg::BUS_IDLE) && bus_valid && ram_hit;
	assign ram.wstrb = bus_wstrb;
	assign ram.index = bus_addr[$bits(icobrd_pkg::mem_index_t)+1:2];
	assign ram.wdata = bus_wdata;

	assign bus_ready = state == icobrd_pkg::BUS_RESP;
	assign bus_rdata = ram_resp ? ram.rdata : rdata_q;

	for (genvar i = 0; i < icobrd_pkg::NUM_PMODS; i++) begin : g_pmod
		assign pmod[i].wr = pmod_wr[i];
		assign pmod[i].rd = pmod_rd[i];
		assign pmod[i].addr = pmod_addr;
		assign pmod[i].wdat = pmod_wdat;
		assign pmod_done[i] = pmod[i].done;
		assign pmod_rdat_vec[i] = pmod[i].rdat;
	end

	// --------------------------------------------------
	// bus fsm

	always_ff @(posedge clk) begin
		if (!cpu_resetn) begin
			state <= icobrd_pkg::BUS_IDLE;
			leds <= '0;
			con_tx_valid <= 1'b0;
			con_rx_ready <= 1'b0;
			pmod_wr <= '0;
			pmod_rd <= '0;
			pmod_sel <= '0;
			ram_resp <= 1'b0;
		end else begin
			pmod_wr <= '0;
			pmod_rd <= '0;
			con_rx_ready <= 1'b0;
			if (con_tx_valid && con_tx_ready)
				con_tx_valid <= 1'b0;
			case (state)
				icobrd_pkg::BUS_IDLE: begin
					if (bus_valid) begin
						ram_resp <= 1'b0;
						if (ram_hit) begin
							ram_resp <= 1'b1;
							state <= icobrd_pkg::BUS_RESP;
						end else if (io_hit && |pmod_hit) begin
							pmod_sel <= pmod_hit;
							if (is_write)
								pmod_wr <= pmod_hit;
							else
								pmod_rd <= pmod_hit;
							state <= icobrd_pkg::BUS_PMOD;
						end else if (io_hit) begin
							// led page or unmapped page
							if (led_hit && is_write)
								leds <= bus_wdata[2:0];
							state <= icobrd_pkg::BUS_RESP;
						end else if (con_hit && is_write) begin
							// stall while the previous byte is still pending
							if (tx_free) begin
								con_tx_valid <= 1'b1;
								state <= icobrd_pkg::BUS_RESP;
							end
						end else if (con_hit) begin
							con_rx_ready <= con_rx_valid;
							state <= icobrd_pkg::BUS_RESP;
						end
					end
				end
				icobrd_pkg::BUS_PMOD: begin
					if (|(pmod_done & pmod_sel))
						state <= icobrd_pkg::BUS_RESP;
				end
				icobrd_pkg::BUS_RESP: state <= icobrd_pkg::BUS_IDLE;
				default: state <= icobrd_pkg::BUS_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// data path

	always_ff @(posedge clk) begin
		if (state == icobrd_pkg::BUS_IDLE) begin
			pmod_addr <= bus_addr[7:0];
			pmod_wdat <= bus_wdata[7:0];
			if (con_hit)
				rdata_q <= con_rx_valid ? icobrd_pkg::word_t'(con_rx_data) :
					icobrd_pkg::CONSOLE_EMPTY;
			else if (led_hit)
				rdata_q <= icobrd_pkg::word_t'(leds);
			else
				rdata_q <= '0;
			if (bus_valid && con_hit && is_write && tx_free)
				con_tx_data <= bus_wdata[7:0];
		end
		// port data is valid in the done cycle
		if (state == icobrd_pkg::BUS_PMOD)
			rdata_q <= icobrd_pkg::word_t'(pmod_rdat);
	end

endmodule

/* verilog/pmod_gpio.sv */
// one PMOD GPIO port: direction, output and input registers behind the PMOD control port
`timescale 1ns/1ps

module pmod_gpio (
	input  logic              clk,
	input  logic              resetn,
	pmod_ctrl_if.dev          ctrl,
	input  icobrd_pkg::gpio_t pad_in,
	output icobrd_pkg::gpio_t pad_dir,
	output icobrd_pkg::gpio_t pad_out
);

	// register writes, done one cycle after the request
	always_ff @(posedge clk) begin
		if (!resetn) begin
			pad_dir <= '0;
			pad_out <= '0;
			ctrl.done <= 1'b0;
		end else begin
			ctrl.done <= ctrl.wr || ctrl.rd;
			if (ctrl.wr) begin
				if (ctrl.addr == icobrd_pkg::PMOD_REG_DIR)
					pad_dir <= ctrl.wdat;
				if (ctrl.addr == icobrd_pkg::PMOD_REG_OUT)
					pad_out <= ctrl.wdat;
			end
		end
	end

	// read data, valid together with done
	always_ff @(posedge clk) begin
		if (ctrl.rd) begin
			case (ctrl.addr)
				icobrd_pkg::PMOD_REG_DIR: ctrl.rdat <= pad_dir;
				icobrd_pkg::PMOD_REG_OUT: ctrl.rdat <= pad_out;
				// pins sampled straight from the pads
				icobrd_pkg::PMOD_REG_IN:  ctrl.rdat <= pad_in;
				default:                  ctrl.rdat <= '0;
			endcase
		end
	end

endmodule
